//--- design/core_controller.sv
`timescale 1ns/1ns

module core_controller import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // core enable and status
  input  logic       fetch_enable_i,
  output logic       ctrl_busy_o,
  output logic       is_decoding_o,

  // decoder
  output logic       deassert_we_o,
  input  logic       illegal_insn_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       instr_valid_i,

  // fetch unit
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_mux_e    pc_mux_o,

  // lsu and jumps
  input  logic       data_req_ex_i,
  input  logic       branch_taken_ex_i,
  input  jump_kind_e jump_in_dec_i,

  // exceptions
  input  logic       exc_req_i,
  input  logic       ext_req_i,
  output logic       exc_ack_o,
  output logic       exc_save_if_o,
  output logic       exc_save_id_o,
  output logic       exc_save_takenbranch_o,
  output logic       exc_restore_id_o,

  // write enables and operand compares from the register file side
  input  logic       regfile_we_ex_i,
  input  logic       regfile_we_wb_i,
  input  logic       regfile_alu_we_fw_i,
  input  logic       reg_d_wb_is_reg_a_i,
  input  logic       reg_d_wb_is_reg_b_i,
  input  logic       reg_d_alu_is_reg_a_i,
  input  logic       reg_d_alu_is_reg_b_i,
  output fw_sel_e    operand_a_fw_sel_o,
  output fw_sel_e    operand_b_fw_sel_o,

  // stalls
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       jr_stall_o,
  output logic       load_stall_o,
  input  logic       id_ready_i,
  input  logic       ex_valid_i
);

  // hazards and forwarding, is_decoding comes back from the FSM
  hazard_unit u_hazard (
    .is_decoding_i        (is_decoding_o),
    .illegal_insn_i       (illegal_insn_i),
    .data_req_ex_i        (data_req_ex_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i  (reg_d_wb_is_reg_b_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i (reg_d_alu_is_reg_b_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .load_stall_o         (load_stall_o),
    .jr_stall_o           (jr_stall_o),
    .deassert_we_o        (deassert_we_o),
    .operand_a_fw_sel_o   (operand_a_fw_sel_o),
    .operand_b_fw_sel_o   (operand_b_fw_sel_o)
  );

  // main control FSM, waits on jr stall before a jalr redirect
  ctrl_fsm u_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .eret_insn_i            (eret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .jr_stall_i             (jr_stall_o),
    .jump_in_dec_i          (jump_in_dec_i),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

endmodule

//--- design/ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// register address width on the decode side
// only the compare results reach the controller
`define CTRL_REG_ADDR_W 5

// select and code widths
`define CTRL_PC_MUX_W 3
`define CTRL_FW_SEL_W 2
`define CTRL_JUMP_W 2
`define CTRL_STATE_W 3

// state loaded by rst_n
`define CTRL_RESET_STATE RESET

`endif

//--- design/ctrl_fsm.sv
`timescale 1ns/1ns

`include "ctrl_config.svh"

module ctrl_fsm import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       branch_taken_ex_i,
  input  logic       exc_req_i,
  input  logic       ext_req_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       jr_stall_i,
  input  jump_kind_e jump_in_dec_i,

  output logic       ctrl_busy_o,
  output logic       is_decoding_o,
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_mux_e    pc_mux_o,
  output logic       exc_ack_o,
  output logic       exc_save_if_o,
  output logic       exc_save_id_o,
  output logic       exc_save_takenbranch_o,
  output logic       exc_restore_id_o,
  output logic       halt_if_o,
  output logic       halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump or eret has redirected, until ID accepts the next one
  logic jump_done_q;
  logic jump_done_d;

  logic is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // by default busy and fetching
    state_d                = state_q;
    jump_done_d            = jump_done_q;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    instr_req_o            = 1'b1;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    unique case (state_q)
      // idle until the core is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch unit
      BOOT_SET: begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // empty pipeline wakes on enable or on an exception request
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // pipe was flushed before sleep, so only IF holds state
        if (exc_req_i) begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        // ID content is only meaningful when no branch in EX redirects
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (is_jump) begin
            pc_mux_o = PC_JUMP;
            // target is known in decode and redirects once per jump
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (exc_req_i) begin
            pc_mux_o      = PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            // keep the faulting instruction out of EX
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          if (eret_insn_i) begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // with nothing in ID the return address comes from IF
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        // taken branch in EX overrides whatever ID wanted
        if (branch_taken_ex_i) begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
          // interrupt returns to the branch target
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
        end
      end

      // let the instruction in EX finish since EX latency is variable
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // one cycle for WB to drain
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= `CTRL_RESET_STATE;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // ID accepting a new instruction releases the guard
      jump_done_q <= jump_done_d && !id_ready_i;
    end
  end

  // no branch prediction in IF, so EX cannot resolve two in a row
  assert property (@(posedge clk) disable iff (!rst_n)
                   branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branches back to back");

  // every exception ack comes with the redirect to the handler
  assert property (@(posedge clk) disable iff (!rst_n)
                   exc_ack_o |-> (pc_set_o && (pc_mux_o == PC_EXCEPTION)))
    else $error("exception ack without redirect");

endmodule

//--- design/ctrl_pkg.sv
`include "ctrl_config.svh"

package ctrl_pkg;

  // source of the next fetch address
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_ERET      = 3'd4
  } pc_mux_e;

  // kind of control transfer seen by the decoder
  typedef enum logic [`CTRL_JUMP_W-1:0] {
    BRANCH_NONE = 2'd0,
    BRANCH_JAL  = 2'd1,
    BRANCH_JALR = 2'd2,
    BRANCH_COND = 2'd3
  } jump_kind_e;

  // operand mux select in ID
  typedef enum logic [`CTRL_FW_SEL_W-1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fw_sel_e;

  // main controller states
  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

endpackage

//--- design/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import ctrl_pkg::*; (
  input  logic       is_decoding_i,
  input  logic       illegal_insn_i,
  input  logic       data_req_ex_i,
  input  logic       regfile_we_ex_i,
  input  logic       regfile_we_wb_i,
  input  logic       regfile_alu_we_fw_i,
  input  logic       reg_d_wb_is_reg_a_i,
  input  logic       reg_d_wb_is_reg_b_i,
  input  logic       reg_d_alu_is_reg_a_i,
  input  logic       reg_d_alu_is_reg_b_i,
  input  jump_kind_e jump_in_dec_i,

  output logic       load_stall_o,
  output logic       jr_stall_o,
  output logic       deassert_we_o,
  output fw_sel_e    operand_a_fw_sel_o,
  output fw_sel_e    operand_b_fw_sel_o
);

  // per-operand select where the younger EX result wins over WB
  function automatic fw_sel_e fw_select(input logic we_wb, input logic wb_hit,
                                        input logic we_alu, input logic alu_hit);
    fw_sel_e sel;
    sel = SEL_REGFILE;
    if (we_wb && wb_hit) begin
      sel = SEL_FW_WB;
    end
    if (we_alu && alu_hit) begin
      sel = SEL_FW_EX;
    end
    return sel;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stalls
  //////////////////////////////////////////////////////////////////////

  // load in EX whose destination is read by the instruction in decode
  assign load_stall_o = data_req_ex_i && regfile_we_ex_i &&
                        (reg_d_alu_is_reg_a_i || reg_d_alu_is_reg_b_i);

  // jalr target register still in flight somewhere down the pipe
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) &&
                      ((regfile_we_wb_i && reg_d_wb_is_reg_a_i) ||
                       (regfile_we_ex_i && reg_d_alu_is_reg_a_i) ||
                       (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i));

  // kill the write enable of whatever sits in ID when it must not commit
  assign deassert_we_o = !is_decoding_i || illegal_insn_i || load_stall_o || jr_stall_o;

  //////////////////////////////////////////////////////////////////////
  // forwarding
  //////////////////////////////////////////////////////////////////////

  assign operand_a_fw_sel_o = fw_select(regfile_we_wb_i, reg_d_wb_is_reg_a_i,
                                        regfile_alu_we_fw_i, reg_d_alu_is_reg_a_i);
  assign operand_b_fw_sel_o = fw_select(regfile_we_wb_i, reg_d_wb_is_reg_b_i,
                                        regfile_alu_we_fw_i, reg_d_alu_is_reg_b_i);

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_core_controller -Mdir obj_dir -o sim_core_controller > build.log 2>&1 \
  && ./obj_dir/sim_core_controller > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

//--- sim/tb_core_controller.sv
`timescale 1ns/1ns

module tb_core_controller import ctrl_pkg::*; ();

  // wait kinds in a table row
  localparam logic [1:0] WAIT_NONE = 2'd0;
  localparam logic [1:0] WAIT_PC_SET = 2'd1;
  localparam logic [1:0] WAIT_ACK = 2'd2;
  localparam int WAIT_LIMIT = 20;
  localparam int HAZARD_VECTORS = 200;

  logic clk;
  logic rst_n;
  logic fetch_enable_i, instr_valid_i, eret_insn_i, pipe_flush_i, illegal_insn_i;
  logic data_req_ex_i, branch_taken_ex_i, exc_req_i, ext_req_i, id_ready_i, ex_valid_i;
  logic regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i;
  jump_kind_e jump_in_dec_i;
  logic ctrl_busy_o, is_decoding_o, deassert_we_o, instr_req_o, pc_set_o;
  logic exc_ack_o, exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o, exc_restore_id_o;
  logic halt_if_o, halt_id_o, jr_stall_o, load_stall_o;
  pc_mux_e pc_mux_o;
  fw_sel_e operand_a_fw_sel_o;
  fw_sel_e operand_b_fw_sel_o;

  int checks;
  int mismatches;
  int timeouts;
  int step;

  // row layout {wait[1:0], stim[12:0], exp[15:0]}
  // stim: fe valid eret flush br exc ext idr exv jump[1:0] we_wb wb_a
  // exp:  busy dec req pc_set mux[2:0] ack s_if s_id s_tb restore h_if h_id jr dwe
  logic [30:0] rows [$];

  core_controller DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h (step %0d)", name, actual, expected, step);
    end
  endtask

  task automatic add_row(input logic [1:0] kind, input logic [12:0] stim,
                         input logic [15:0] exp);
    rows.push_back({kind, stim, exp});
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // reset idle, then boot with a single pc_set
    add_row(WAIT_NONE,   13'b0_0_0_0_0_0_0_0_0_00_0_0, 16'b0_0_0_0_000_0_0_0_0_0_0_0_0_1);
    add_row(WAIT_PC_SET, 13'b1_0_0_0_0_0_0_0_0_00_0_0, 16'b1_0_1_1_000_0_0_0_0_0_0_0_0_1);
    add_row(WAIT_NONE,   13'b1_0_0_0_0_0_0_0_0_00_0_0, 16'b1_0_1_0_000_0_0_0_0_0_0_0_0_1);
    // first fetch ignores a valid instruction
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_00_0_0, 16'b1_0_1_0_000_0_0_0_0_0_0_0_0_1);
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_00_0_0, 16'b1_1_1_0_000_0_0_0_0_0_0_0_0_0);
    // jal under back-pressure, one redirect only
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_0_0_01_0_0, 16'b1_1_1_1_001_0_0_0_0_0_0_0_0_0);
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_0_0_01_0_0, 16'b1_1_1_0_001_0_0_0_0_0_0_0_0_0);
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_01_0_0, 16'b1_1_1_0_001_0_0_0_0_0_0_0_0_0);
    // guard released, next jump redirects
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_01_0_0, 16'b1_1_1_1_001_0_0_0_0_0_0_0_0_0);
    // jalr behind a WB write of its base register
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_0_0_10_1_1, 16'b1_1_1_0_001_0_0_0_0_0_0_0_1_1);
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_00_0_0, 16'b1_1_1_0_000_0_0_0_0_0_0_0_0_0);
    // exception on an ALU instruction in ID
    add_row(WAIT_ACK,    13'b1_1_0_0_0_1_0_1_0_00_0_0, 16'b1_1_1_1_011_1_0_1_0_0_0_1_0_0);
    add_row(WAIT_NONE,   13'b1_1_0_0_1_0_0_1_0_00_0_0, 16'b1_0_1_1_010_0_0_0_0_0_0_0_0_1);
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_00_0_0, 16'b1_1_1_0_000_0_0_0_0_0_0_0_0_0);
    // interrupt together with a taken branch
    add_row(WAIT_ACK,    13'b1_1_0_0_1_0_1_1_0_00_0_0, 16'b1_0_1_1_011_1_0_0_1_0_0_1_0_1);
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_00_0_0, 16'b1_1_1_0_000_0_0_0_0_0_0_0_0_0);
    // flush with fetch disabled, EX finishes late
    add_row(WAIT_NONE,   13'b0_1_0_1_0_0_0_1_0_00_0_0, 16'b1_1_1_0_000_0_0_0_0_0_1_1_0_0);
    add_row(WAIT_NONE,   13'b0_0_0_0_0_0_0_0_0_00_0_0, 16'b1_0_1_0_000_0_0_0_0_0_1_1_0_1);
    add_row(WAIT_NONE,   13'b0_0_0_0_0_0_0_0_0_00_0_0, 16'b1_0_1_0_000_0_0_0_0_0_1_1_0_1);
    add_row(WAIT_NONE,   13'b0_0_0_0_0_0_0_0_1_00_0_0, 16'b1_0_1_0_000_0_0_0_0_0_1_1_0_1);
    add_row(WAIT_NONE,   13'b0_0_0_0_0_0_0_0_0_00_0_0, 16'b1_0_1_0_000_0_0_0_0_0_1_1_0_1);
    // asleep, then woken by an exception request
    add_row(WAIT_NONE,   13'b0_0_0_0_0_0_0_0_0_00_0_0, 16'b0_0_0_0_000_0_0_0_0_0_1_1_0_1);
    add_row(WAIT_ACK,    13'b0_0_0_0_0_1_0_0_0_00_0_0, 16'b1_0_1_1_011_1_1_0_0_0_0_0_0_1);
    add_row(WAIT_NONE,   13'b1_0_0_0_0_0_0_1_0_00_0_0, 16'b1_0_1_0_000_0_0_0_0_0_0_0_0_1);
    // eret with fetch enabled, held for a second cycle
    add_row(WAIT_NONE,   13'b1_1_1_0_0_0_0_0_0_00_0_0, 16'b1_1_1_1_100_0_0_0_0_1_0_0_0_0);
    add_row(WAIT_NONE,   13'b1_1_1_0_0_0_0_0_0_00_0_0, 16'b1_1_1_0_100_0_0_0_0_1_0_0_0_0);
    add_row(WAIT_NONE,   13'b1_1_0_0_0_0_0_1_0_00_0_0, 16'b1_1_1_0_000_0_0_0_0_0_0_0_0_0);
  endtask

  task automatic init_inputs();
    rst_n <= 1'b0;
    fetch_enable_i <= 1'b0;
    instr_valid_i <= 1'b0;
    eret_insn_i <= 1'b0;
    pipe_flush_i <= 1'b0;
    illegal_insn_i <= 1'b0;
    data_req_ex_i <= 1'b0;
    branch_taken_ex_i <= 1'b0;
    exc_req_i <= 1'b0;
    ext_req_i <= 1'b0;
    id_ready_i <= 1'b0;
    ex_valid_i <= 1'b0;
    regfile_we_ex_i <= 1'b0;
    regfile_we_wb_i <= 1'b0;
    regfile_alu_we_fw_i <= 1'b0;
    reg_d_wb_is_reg_a_i <= 1'b0;
    reg_d_wb_is_reg_b_i <= 1'b0;
    reg_d_alu_is_reg_a_i <= 1'b0;
    reg_d_alu_is_reg_b_i <= 1'b0;
    jump_in_dec_i <= BRANCH_NONE;
  endtask

  task automatic drive_row(input logic [12:0] stim);
    fetch_enable_i <= stim[12];
    instr_valid_i <= stim[11];
    eret_insn_i <= stim[10];
    pipe_flush_i <= stim[9];
    branch_taken_ex_i <= stim[8];
    exc_req_i <= stim[7];
    ext_req_i <= stim[6];
    id_ready_i <= stim[5];
    ex_valid_i <= stim[4];
    jump_in_dec_i <= jump_kind_e'(stim[3:2]);
    regfile_we_wb_i <= stim[1];
    reg_d_wb_is_reg_a_i <= stim[0];
  endtask

  task automatic check_outputs(input logic [15:0] exp);
    check("ctrl_busy_o", 32'(ctrl_busy_o), 32'(exp[15]));
    check("is_decoding_o", 32'(is_decoding_o), 32'(exp[14]));
    check("instr_req_o", 32'(instr_req_o), 32'(exp[13]));
    check("pc_set_o", 32'(pc_set_o), 32'(exp[12]));
    // the mux value only matters while the PC is being set
    if (exp[12]) begin
      check("pc_mux_o", 32'(pc_mux_o), 32'(exp[11:9]));
    end
    check("exc_ack_o", 32'(exc_ack_o), 32'(exp[8]));
    check("exc_save_if_o", 32'(exc_save_if_o), 32'(exp[7]));
    check("exc_save_id_o", 32'(exc_save_id_o), 32'(exp[6]));
    check("exc_save_takenbranch_o", 32'(exc_save_takenbranch_o), 32'(exp[5]));
    check("exc_restore_id_o", 32'(exc_restore_id_o), 32'(exp[4]));
    check("halt_if_o", 32'(halt_if_o), 32'(exp[3]));
    check("halt_id_o", 32'(halt_id_o), 32'(exp[2]));
    check("jr_stall_o", 32'(jr_stall_o), 32'(exp[1]));
    check("deassert_we_o", 32'(deassert_we_o), 32'(exp[0]));
  endtask

  function automatic logic wait_hit(input logic [1:0] kind);
    return (kind == WAIT_ACK) ? exc_ack_o : pc_set_o;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [30:0] row;
    logic [31:0] rnd;
    logic exp_load;
    logic exp_jr;
    fw_sel_e exp_a;
    fw_sel_e exp_b;
    int cycles;

    checks = 0;
    mismatches = 0;
    timeouts = 0;
    step = 0;
    init_inputs();
    build_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // FSM table, outputs sampled mid-cycle
    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      step = i;
      @(posedge clk);
      drive_row(row[28:16]);
      @(negedge clk);
      if (row[30:29] != WAIT_NONE) begin
        cycles = 0;
        while (!wait_hit(row[30:29]) && cycles < WAIT_LIMIT) begin
          @(negedge clk);
          cycles++;
        end
        if (!wait_hit(row[30:29])) begin
          timeouts++;
          $display("Timeout: step %0d waited %0d cycles for the handshake", i, WAIT_LIMIT);
        end
      end
      check_outputs(row[15:0]);
    end

    // random hazard vectors, controller stays in DECODE
    rnd = 32'h27c2;
    for (int i = 0; i < HAZARD_VECTORS; i++) begin
      step = 1000 + i;
      rnd = xorshift(rnd);
      @(posedge clk);
      instr_valid_i <= rnd[0];
      illegal_insn_i <= rnd[1];
      data_req_ex_i <= rnd[2];
      regfile_we_ex_i <= rnd[3];
      regfile_we_wb_i <= rnd[4];
      regfile_alu_we_fw_i <= rnd[5];
      reg_d_wb_is_reg_a_i <= rnd[6];
      reg_d_wb_is_reg_b_i <= rnd[7];
      reg_d_alu_is_reg_a_i <= rnd[8];
      reg_d_alu_is_reg_b_i <= rnd[9];
      jump_in_dec_i <= jump_kind_e'(rnd[11:10]);
      @(negedge clk);
      // load in EX feeding either ALU operand
      exp_load = rnd[2] & rnd[3] & (rnd[8] | rnd[9]);
      // jalr base register pending in WB, EX or the ALU port
      exp_jr = (rnd[11:10] == 2'd2) & ((rnd[4] & rnd[6]) | ((rnd[3] | rnd[5]) & rnd[8]));
      exp_a = (rnd[5] & rnd[8]) ? SEL_FW_EX : ((rnd[4] & rnd[6]) ? SEL_FW_WB : SEL_REGFILE);
      exp_b = (rnd[5] & rnd[9]) ? SEL_FW_EX : ((rnd[4] & rnd[7]) ? SEL_FW_WB : SEL_REGFILE);
      check("load_stall_o", 32'(load_stall_o), 32'(exp_load));
      check("jr_stall_o", 32'(jr_stall_o), 32'(exp_jr));
      check("deassert_we_o", 32'(deassert_we_o), 32'(!rnd[0] | rnd[1] | exp_load | exp_jr));
      check("operand_a_fw_sel_o", 32'(operand_a_fw_sel_o), 32'(exp_a));
      check("operand_b_fw_sel_o", 32'(operand_b_fw_sel_o), 32'(exp_b));
    end

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+design
design/ctrl_pkg.sv
design/hazard_unit.sv
design/ctrl_fsm.sv
design/core_controller.sv
sim/tb_core_controller.sv
